// File: verilog/rob_pkg.sv
package rob_pkg;

    // buffer geometry
    localparam int ROB_DEPTH = 16;
    localparam int ROB_ADDR_W = 4;
    // one extra bit tells full from empty
    localparam int ROB_PTR_W = ROB_ADDR_W + 1;

    // lanes and ports
    localparam int DISPATCH_WIDTH = 2;
    localparam int RETIRE_WIDTH = 2;
    localparam int COMPLETE_PORTS = 2;

    // payload widths
    localparam int REG_ADDR_W = 5;
    localparam int DATA_W = 32;
    localparam int EXC_CODE_W = 4;

    // slot index into the table
    typedef logic [ROB_ADDR_W-1:0] rob_addr_t;

    // head or tail pointer, msb is the wrap bit
    typedef logic [ROB_PTR_W-1:0] rob_ptr_t;

    // architectural destination register
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // result value from an execute unit
    typedef logic [DATA_W-1:0] data_t;

    // exception cause reported on completion
    typedef logic [EXC_CODE_W-1:0] exc_code_t;

endpackage

// File: verilog/rob_alloc.sv
`timescale 1ns/10ps

module rob_alloc (
    input  logic                                                clk,
    input  logic                                                reset,
    input  logic               [rob_pkg::DISPATCH_WIDTH-1:0]    dispatch_valid,
    input  rob_pkg::reg_addr_t [rob_pkg::DISPATCH_WIDTH-1:0]    dispatch_dest,
    input  rob_pkg::rob_ptr_t                                   head_ptr,
    input  logic                                                flush,
    output rob_pkg::rob_addr_t [rob_pkg::DISPATCH_WIDTH-1:0]    dispatch_addr,
    output logic                                                dispatch_stall,
    output logic               [rob_pkg::DISPATCH_WIDTH-1:0]    alloc_we,
    output rob_pkg::rob_addr_t [rob_pkg::DISPATCH_WIDTH-1:0]    alloc_addr,
    output rob_pkg::reg_addr_t [rob_pkg::DISPATCH_WIDTH-1:0]    alloc_dest
);

    rob_pkg::rob_ptr_t tail_ptr;
    rob_pkg::rob_ptr_t used_slots;
    rob_pkg::rob_ptr_t free_slots;
    rob_pkg::rob_ptr_t alloc_count;

    // wrap bit keeps the difference exact, 0 up to ROB_DEPTH
    assign used_slots = tail_ptr - head_ptr;
    assign free_slots = rob_pkg::rob_ptr_t'(rob_pkg::ROB_DEPTH) - used_slots;

    assign dispatch_stall = free_slots < rob_pkg::DISPATCH_WIDTH;

    // consecutive slots from the tail, idle lanes skip
    always_comb begin : lane_slots
        rob_pkg::rob_addr_t slot;
        slot = tail_ptr[rob_pkg::ROB_ADDR_W-1:0];
        for (int i = 0; i < rob_pkg::DISPATCH_WIDTH; i++) begin
            dispatch_addr[i] = slot;
            if (dispatch_valid[i]) begin
                slot = slot + 1'b1;
            end
        end
    end

    // drop strobes while stalled or flushing
    always_comb begin
        alloc_count = '0;
        for (int i = 0; i < rob_pkg::DISPATCH_WIDTH; i++) begin
            alloc_we[i] = dispatch_valid[i] & ~dispatch_stall & ~flush;
            alloc_count = alloc_count + rob_pkg::rob_ptr_t'(alloc_we[i]);
        end
    end

    assign alloc_addr = dispatch_addr;
    assign alloc_dest = dispatch_dest;

    always_ff @(posedge clk) begin
        if (reset) begin
            tail_ptr <= '0;
        end else if (flush) begin
            tail_ptr <= '0;
        end else begin
            tail_ptr <= tail_ptr + alloc_count;
        end
    end

endmodule

// File: verilog/rob_table.sv
`timescale 1ns/10ps

module rob_table (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                                                 flush,
    input  logic                [rob_pkg::DISPATCH_WIDTH-1:0]    alloc_we,
    input  rob_pkg::rob_addr_t  [rob_pkg::DISPATCH_WIDTH-1:0]    alloc_addr,
    input  rob_pkg::reg_addr_t  [rob_pkg::DISPATCH_WIDTH-1:0]    alloc_dest,
    input  logic                [rob_pkg::COMPLETE_PORTS-1:0]    complete_valid,
    input  rob_pkg::rob_addr_t  [rob_pkg::COMPLETE_PORTS-1:0]    complete_addr,
    input  rob_pkg::data_t      [rob_pkg::COMPLETE_PORTS-1:0]    complete_data,
    input  logic                [rob_pkg::COMPLETE_PORTS-1:0]    complete_exc,
    input  rob_pkg::exc_code_t  [rob_pkg::COMPLETE_PORTS-1:0]    complete_exc_code,
    input  rob_pkg::rob_addr_t                                   head_addr,
    input  logic                [rob_pkg::RETIRE_WIDTH-1:0]      retire_valid,
    output logic                [rob_pkg::RETIRE_WIDTH-1:0]      head_valid,
    output logic                [rob_pkg::RETIRE_WIDTH-1:0]      head_complete,
    output logic                [rob_pkg::RETIRE_WIDTH-1:0]      head_exc,
    output rob_pkg::exc_code_t  [rob_pkg::RETIRE_WIDTH-1:0]      head_exc_code,
    output rob_pkg::reg_addr_t  [rob_pkg::RETIRE_WIDTH-1:0]      head_dest,
    output rob_pkg::data_t      [rob_pkg::RETIRE_WIDTH-1:0]      head_data
);

    // per-slot status
    logic [rob_pkg::ROB_DEPTH-1:0] entry_valid;
    logic [rob_pkg::ROB_DEPTH-1:0] entry_complete;
    logic [rob_pkg::ROB_DEPTH-1:0] entry_exc;

    // per-slot payload
    rob_pkg::exc_code_t entry_code [rob_pkg::ROB_DEPTH];
    rob_pkg::reg_addr_t entry_dest [rob_pkg::ROB_DEPTH];
    rob_pkg::data_t     entry_data [rob_pkg::ROB_DEPTH];

    // head and the slots after it, wrapping
    rob_pkg::rob_addr_t [rob_pkg::RETIRE_WIDTH-1:0] rd_addr;

    always_comb begin
        for (int i = 0; i < rob_pkg::RETIRE_WIDTH; i++) begin
            rd_addr[i] = head_addr + rob_pkg::rob_addr_t'(i);
        end
    end

    // completion, then retire clear, then dispatch
    always_ff @(posedge clk) begin
        if (reset) begin
            entry_valid <= '0;
            entry_complete <= '0;
            entry_exc <= '0;
        end else if (flush) begin
            entry_valid <= '0;
        end else begin
            for (int p = 0; p < rob_pkg::COMPLETE_PORTS; p++) begin
                if (complete_valid[p]) begin
                    entry_complete[complete_addr[p]] <= 1'b1;
                    entry_exc[complete_addr[p]] <= complete_exc[p];
                end
            end
            for (int r = 0; r < rob_pkg::RETIRE_WIDTH; r++) begin
                if (retire_valid[r]) begin
                    entry_valid[rd_addr[r]] <= 1'b0;
                end
            end
            for (int l = 0; l < rob_pkg::DISPATCH_WIDTH; l++) begin
                if (alloc_we[l]) begin
                    entry_valid[alloc_addr[l]] <= 1'b1;
                    entry_complete[alloc_addr[l]] <= 1'b0;
                    entry_exc[alloc_addr[l]] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < rob_pkg::COMPLETE_PORTS; p++) begin
            if (complete_valid[p] && !flush) begin
                entry_code[complete_addr[p]] <= complete_exc_code[p];
                entry_data[complete_addr[p]] <= complete_data[p];
            end
        end
        // alloc_we is already low in a flush cycle
        for (int l = 0; l < rob_pkg::DISPATCH_WIDTH; l++) begin
            if (alloc_we[l]) begin
                entry_dest[alloc_addr[l]] <= alloc_dest[l];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < rob_pkg::RETIRE_WIDTH; i++) begin
            head_valid[i] = entry_valid[rd_addr[i]];
            head_complete[i] = entry_complete[rd_addr[i]];
            head_exc[i] = entry_exc[rd_addr[i]];
            head_exc_code[i] = entry_code[rd_addr[i]];
            head_dest[i] = entry_dest[rd_addr[i]];
            head_data[i] = entry_data[rd_addr[i]];
        end
    end

endmodule

// File: verilog/rob_retire.sv
`timescale 1ns/10ps

module rob_retire (
    input  logic                                               clk,
    input  logic                                               reset,
    input  logic               [rob_pkg::RETIRE_WIDTH-1:0]     head_valid,
    input  logic               [rob_pkg::RETIRE_WIDTH-1:0]     head_complete,
    input  logic               [rob_pkg::RETIRE_WIDTH-1:0]     head_exc,
    input  rob_pkg::exc_code_t [rob_pkg::RETIRE_WIDTH-1:0]     head_exc_code,
    input  rob_pkg::reg_addr_t [rob_pkg::RETIRE_WIDTH-1:0]     head_dest,
    input  rob_pkg::data_t     [rob_pkg::RETIRE_WIDTH-1:0]     head_data,
    output rob_pkg::rob_addr_t                                 head_addr,
    output rob_pkg::rob_ptr_t                                  head_ptr,
    output logic               [rob_pkg::RETIRE_WIDTH-1:0]     retire_valid,
    output rob_pkg::reg_addr_t [rob_pkg::RETIRE_WIDTH-1:0]     retire_dest,
    output rob_pkg::data_t     [rob_pkg::RETIRE_WIDTH-1:0]     retire_data,
    output logic                                               flush,
    output rob_pkg::exc_code_t                                 flush_code,
    output rob_pkg::reg_addr_t                                 flush_dest
);

    rob_pkg::rob_ptr_t retire_count;
    logic [rob_pkg::RETIRE_WIDTH-1:0] ready;

    assign head_addr = head_ptr[rob_pkg::ROB_ADDR_W-1:0];

    // finished without exception
    assign ready = head_valid & head_complete & ~head_exc;

    // in-order prefix of ready entries
    always_comb begin : retire_select
        logic in_order;
        in_order = 1'b1;
        retire_count = '0;
        for (int i = 0; i < rob_pkg::RETIRE_WIDTH; i++) begin
            retire_valid[i] = in_order & ready[i];
            in_order = retire_valid[i];
            retire_count = retire_count + rob_pkg::rob_ptr_t'(retire_valid[i]);
            retire_dest[i] = head_dest[i];
            retire_data[i] = head_data[i];
        end
    end

    // first entry that does not retire decides the flush
    always_comb begin : exc_detect
        logic blocked_seen;
        blocked_seen = 1'b0;
        flush = 1'b0;
        flush_code = '0;
        flush_dest = '0;
        for (int i = 0; i < rob_pkg::RETIRE_WIDTH; i++) begin
            if (!blocked_seen && !retire_valid[i]) begin
                blocked_seen = 1'b1;
                if (head_valid[i] && head_complete[i] && head_exc[i]) begin
                    flush = 1'b1;
                    flush_code = head_exc_code[i];
                    flush_dest = head_dest[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            head_ptr <= '0;
        end else if (flush) begin
            // buffer restarts empty at slot 0
            head_ptr <= '0;
        end else begin
            head_ptr <= head_ptr + retire_count;
        end
    end

endmodule

// File: verilog/rob_top.sv
`timescale 1ns/10ps

module rob_top (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic                [rob_pkg::DISPATCH_WIDTH-1:0]    dispatch_valid,
    input  rob_pkg::reg_addr_t  [rob_pkg::DISPATCH_WIDTH-1:0]    dispatch_dest,
    output rob_pkg::rob_addr_t  [rob_pkg::DISPATCH_WIDTH-1:0]    dispatch_addr,
    output logic                                                 dispatch_stall,
    input  logic                [rob_pkg::COMPLETE_PORTS-1:0]    complete_valid,
    input  rob_pkg::rob_addr_t  [rob_pkg::COMPLETE_PORTS-1:0]    complete_addr,
    input  rob_pkg::data_t      [rob_pkg::COMPLETE_PORTS-1:0]    complete_data,
    input  logic                [rob_pkg::COMPLETE_PORTS-1:0]    complete_exc,
    input  rob_pkg::exc_code_t  [rob_pkg::COMPLETE_PORTS-1:0]    complete_exc_code,
    output logic                [rob_pkg::RETIRE_WIDTH-1:0]      retire_valid,
    output rob_pkg::reg_addr_t  [rob_pkg::RETIRE_WIDTH-1:0]      retire_dest,
    output rob_pkg::data_t      [rob_pkg::RETIRE_WIDTH-1:0]      retire_data,
    output logic                                                 flush,
    output rob_pkg::exc_code_t                                   flush_code,
    output rob_pkg::reg_addr_t                                   flush_dest
);

    // dispatch writes into the table
    logic               [rob_pkg::DISPATCH_WIDTH-1:0] alloc_we;
    rob_pkg::rob_addr_t [rob_pkg::DISPATCH_WIDTH-1:0] alloc_addr;
    rob_pkg::reg_addr_t [rob_pkg::DISPATCH_WIDTH-1:0] alloc_dest;

    // head read path
    rob_pkg::rob_addr_t                               head_addr;
    rob_pkg::rob_ptr_t                                head_ptr;
    logic               [rob_pkg::RETIRE_WIDTH-1:0]   head_valid;
    logic               [rob_pkg::RETIRE_WIDTH-1:0]   head_complete;
    logic               [rob_pkg::RETIRE_WIDTH-1:0]   head_exc;
    rob_pkg::exc_code_t [rob_pkg::RETIRE_WIDTH-1:0]   head_exc_code;
    rob_pkg::reg_addr_t [rob_pkg::RETIRE_WIDTH-1:0]   head_dest;
    rob_pkg::data_t     [rob_pkg::RETIRE_WIDTH-1:0]   head_data;

    rob_alloc i_rob_alloc (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_dest  (dispatch_dest),
        .head_ptr       (head_ptr),
        .flush          (flush),
        .dispatch_addr  (dispatch_addr),
        .dispatch_stall (dispatch_stall),
        .alloc_we       (alloc_we),
        .alloc_addr     (alloc_addr),
        .alloc_dest     (alloc_dest)
    );

    rob_table i_rob_table (
        .clk               (clk),
        .reset             (reset),
        .flush             (flush),
        .alloc_we          (alloc_we),
        .alloc_addr        (alloc_addr),
        .alloc_dest        (alloc_dest),
        .complete_valid    (complete_valid),
        .complete_addr     (complete_addr),
        .complete_data     (complete_data),
        .complete_exc      (complete_exc),
        .complete_exc_code (complete_exc_code),
        .head_addr         (head_addr),
        .retire_valid      (retire_valid),
        .head_valid        (head_valid),
        .head_complete     (head_complete),
        .head_exc          (head_exc),
        .head_exc_code     (head_exc_code),
        .head_dest         (head_dest),
        .head_data         (head_data)
    );

    rob_retire i_rob_retire (
        .clk           (clk),
        .reset         (reset),
        .head_valid    (head_valid),
        .head_complete (head_complete),
        .head_exc      (head_exc),
        .head_exc_code (head_exc_code),
        .head_dest     (head_dest),
        .head_data     (head_data),
        .head_addr     (head_addr),
        .head_ptr      (head_ptr),
        .retire_valid  (retire_valid),
        .retire_dest   (retire_dest),
        .retire_data   (retire_data),
        .flush         (flush),
        .flush_code    (flush_code),
        .flush_dest    (flush_dest)
    );

endmodule

// File: verification/rob_properties.sv
`timescale 1ns/10ps

module rob_properties (
    input logic                               clk,
    input logic                               reset,
    input logic [rob_pkg::RETIRE_WIDTH-1:0]   retire_valid,
    input logic                               dispatch_stall,
    input logic                               flush
);

    // lane 1 only retires behind lane 0
    lane_order: assert property (@(posedge clk) disable iff (reset)
        retire_valid[1] |-> retire_valid[0])
        else $error("retire lane 1 active without lane 0");

    flush_single: assert property (@(posedge clk) disable iff (reset)
        flush |=> !flush)
        else $error("flush held for more than one cycle");

    // buffer is empty once the flush is taken
    flush_empty: assert property (@(posedge clk) disable iff (reset)
        flush |=> (retire_valid == '0 && !dispatch_stall))
        else $error("retire or stall in the cycle after flush");

    reset_quiet: assert property (@(posedge clk)
        reset |=> (retire_valid == '0 && !dispatch_stall && !flush))
        else $error("outputs not quiet after reset");

endmodule

bind rob_top rob_properties i_rob_properties (
    .clk            (clk),
    .reset          (reset),
    .retire_valid   (retire_valid),
    .dispatch_stall (dispatch_stall),
    .flush          (flush)
);

// File: verification/tb_rob_top.sv
`timescale 1ns/10ps

module tb_rob_top;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 8;
    localparam int TEST_CYCLES = 4000;
    localparam int DRIVE_DELAY = 10;

    logic                                              clk;
    logic                                              reset;
    logic               [rob_pkg::DISPATCH_WIDTH-1:0]  dispatch_valid;
    rob_pkg::reg_addr_t [rob_pkg::DISPATCH_WIDTH-1:0]  dispatch_dest;
    rob_pkg::rob_addr_t [rob_pkg::DISPATCH_WIDTH-1:0]  dispatch_addr;
    logic                                              dispatch_stall;
    logic               [rob_pkg::COMPLETE_PORTS-1:0]  complete_valid;
    rob_pkg::rob_addr_t [rob_pkg::COMPLETE_PORTS-1:0]  complete_addr;
    rob_pkg::data_t     [rob_pkg::COMPLETE_PORTS-1:0]  complete_data;
    logic               [rob_pkg::COMPLETE_PORTS-1:0]  complete_exc;
    rob_pkg::exc_code_t [rob_pkg::COMPLETE_PORTS-1:0]  complete_exc_code;
    logic               [rob_pkg::RETIRE_WIDTH-1:0]    retire_valid;
    rob_pkg::reg_addr_t [rob_pkg::RETIRE_WIDTH-1:0]    retire_dest;
    rob_pkg::data_t     [rob_pkg::RETIRE_WIDTH-1:0]    retire_data;
    logic                                              flush;
    rob_pkg::exc_code_t                                flush_code;
    rob_pkg::reg_addr_t                                flush_dest;

    // reference model in program order, oldest first
    rob_pkg::rob_addr_t q_slot [$];
    rob_pkg::reg_addr_t q_dest [$];
    logic               q_done [$];
    logic               q_exc [$];
    rob_pkg::exc_code_t q_code [$];
    rob_pkg::data_t     q_data [$];
    rob_pkg::rob_addr_t model_tail;

    // expected outputs of the current cycle
    int                 exp_retire;
    logic               exp_flush;
    logic               exp_stall;
    rob_pkg::exc_code_t exp_code;
    rob_pkg::reg_addr_t exp_fdest;
    int                 comp_idx [rob_pkg::COMPLETE_PORTS];

    int seed_val;
    int flush_count;
    int stall_count;
    int dual_count;

    rob_top i_rob_top (
        .clk               (clk),
        .reset             (reset),
        .dispatch_valid    (dispatch_valid),
        .dispatch_dest     (dispatch_dest),
        .dispatch_addr     (dispatch_addr),
        .dispatch_stall    (dispatch_stall),
        .complete_valid    (complete_valid),
        .complete_addr     (complete_addr),
        .complete_data     (complete_data),
        .complete_exc      (complete_exc),
        .complete_exc_code (complete_exc_code),
        .retire_valid      (retire_valid),
        .retire_dest       (retire_dest),
        .retire_data       (retire_data),
        .flush             (flush),
        .flush_code        (flush_code),
        .flush_dest        (flush_dest)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    // retire prefix, flush and stall from the model state
    task automatic predict();
        int n;
        n = 0;
        exp_flush = 1'b0;
        exp_code = '0;
        exp_fdest = '0;
        while (n < rob_pkg::RETIRE_WIDTH && n < q_slot.size() && q_done[n] && !q_exc[n]) begin
            n++;
        end
        exp_retire = n;
        if (n < rob_pkg::RETIRE_WIDTH && n < q_slot.size() && q_done[n] && q_exc[n]) begin
            exp_flush = 1'b1;
            exp_code = q_code[n];
            exp_fdest = q_dest[n];
        end
        exp_stall = (rob_pkg::ROB_DEPTH - q_slot.size()) < rob_pkg::DISPATCH_WIDTH;
    endtask

    task automatic drive_inputs(input logic hold);
        int cand [$];
        int k;
        for (int i = 0; i < q_slot.size(); i++) begin
            if (!q_done[i]) begin
                cand.push_back(i);
            end
        end
        for (int l = 0; l < rob_pkg::DISPATCH_WIDTH; l++) begin
            dispatch_dest[l] = rob_pkg::reg_addr_t'($urandom);
            dispatch_valid[l] = 1'b0;
            if (!exp_stall && !exp_flush) begin
                dispatch_valid[l] = hold || ($urandom_range(1, 0) == 1);
            end
        end
        // distinct outstanding entries, none during a hold burst
        for (int p = 0; p < rob_pkg::COMPLETE_PORTS; p++) begin
            comp_idx[p] = -1;
            complete_valid[p] = 1'b0;
            complete_addr[p] = '0;
            complete_data[p] = rob_pkg::data_t'($urandom);
            complete_exc[p] = ($urandom_range(15, 0) == 0);
            complete_exc_code[p] = rob_pkg::exc_code_t'($urandom);
            if (!hold && cand.size() > 0 && $urandom_range(3, 0) != 0) begin
                k = $urandom_range(cand.size() - 1, 0);
                comp_idx[p] = cand[k];
                cand.delete(k);
                complete_valid[p] = 1'b1;
                complete_addr[p] = q_slot[comp_idx[p]];
            end
        end
    endtask

    task automatic check_outputs();
        rob_pkg::rob_addr_t slot;
        check("dispatch_stall", exp_stall, dispatch_stall);
        check("flush", exp_flush, flush);
        if (exp_flush) begin
            check("flush_code", exp_code, flush_code);
            check("flush_dest", exp_fdest, flush_dest);
        end
        for (int r = 0; r < rob_pkg::RETIRE_WIDTH; r++) begin
            check($sformatf("retire_valid[%0d]", r), r < exp_retire, retire_valid[r]);
            if (r < exp_retire) begin
                check($sformatf("retire_dest[%0d]", r), q_dest[r], retire_dest[r]);
                check($sformatf("retire_data[%0d]", r), q_data[r], retire_data[r]);
            end
        end
        slot = model_tail;
        for (int l = 0; l < rob_pkg::DISPATCH_WIDTH; l++) begin
            if (dispatch_valid[l]) begin
                check($sformatf("dispatch_addr[%0d]", l), slot, dispatch_addr[l]);
                slot = slot + 1'b1;
            end
        end
    endtask

    // apply what the coming clock edge commits
    task automatic update_model();
        if (exp_flush) begin
            flush_count++;
            q_slot.delete();
            q_dest.delete();
            q_done.delete();
            q_exc.delete();
            q_code.delete();
            q_data.delete();
            model_tail = '0;
        end else begin
            if (comp_idx[0] >= 0 && comp_idx[1] >= 0) begin
                dual_count++;
            end
            for (int p = 0; p < rob_pkg::COMPLETE_PORTS; p++) begin
                if (comp_idx[p] >= 0) begin
                    q_done[comp_idx[p]] = 1'b1;
                    q_exc[comp_idx[p]] = complete_exc[p];
                    q_code[comp_idx[p]] = complete_exc_code[p];
                    q_data[comp_idx[p]] = complete_data[p];
                end
            end
            for (int r = 0; r < exp_retire; r++) begin
                void'(q_slot.pop_front());
                void'(q_dest.pop_front());
                void'(q_done.pop_front());
                void'(q_exc.pop_front());
                void'(q_code.pop_front());
                void'(q_data.pop_front());
            end
            for (int l = 0; l < rob_pkg::DISPATCH_WIDTH; l++) begin
                if (dispatch_valid[l]) begin
                    q_slot.push_back(model_tail);
                    q_dest.push_back(dispatch_dest[l]);
                    q_done.push_back(1'b0);
                    q_exc.push_back(1'b0);
                    q_code.push_back('0);
                    q_data.push_back('0);
                    model_tail = model_tail + 1'b1;
                end
            end
        end
    endtask

    initial begin : watchdog
        #((RESET_CYCLES + TEST_CYCLES + 50) * CLK_PERIOD);
        $display("watchdog expired, the test did not finish in time");
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation timeout");
    end

    initial begin
        flush_count = 0;
        stall_count = 0;
        dual_count = 0;
        seed_val = $urandom(32'ha5f8_bde1);
        reset = 1'b1;
        dispatch_valid = '0;
        dispatch_dest = '0;
        complete_valid = '0;
        complete_addr = '0;
        complete_data = '0;
        complete_exc = '0;
        complete_exc_code = '0;
        model_tail = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY);
        reset = 1'b0;
        for (int c = 0; c < TEST_CYCLES; c++) begin
            predict();
            if (exp_stall) begin
                stall_count++;
            end
            // bursts without completions fill the buffer
            drive_inputs((c % 250) >= 150 && (c % 250) < 200);
            @(negedge clk);
            check_outputs();
            update_model();
            @(posedge clk);
            #(DRIVE_DELAY);
        end
        if (flush_count == 0 || stall_count == 0 || dual_count == 0) begin
            $display("stimulus never reached a flush, a full buffer or a dual completion");
            $display("*** TEST FAILED ***");
            $fatal(1, "stimulus did not reach every scenario");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

// File: rob_sys.f
verilog/rob_pkg.sv
verilog/rob_alloc.sv
verilog/rob_table.sv
verilog/rob_retire.sv
verilog/rob_top.sv
verification/rob_properties.sv
verification/tb_rob_top.sv
